// File: source/mips_config.svh
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// Boot vector, first fetch after reset
`define MIPS_RESET_PC 32'hBFC0_0000

// General purpose registers, r0 included
`define MIPS_REG_COUNT 32

`endif

// File: source/mips_pkg.sv
`default_nettype none

package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [63:0] dword_t;
	typedef logic [31:0] inst_addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [4:0]  oper_t;

	// Internal operation codes, I-type forms share the R-type code
	localparam oper_t OP_NOP   = 5'd0;
	localparam oper_t OP_ADDU  = 5'd1;
	localparam oper_t OP_SUBU  = 5'd2;
	localparam oper_t OP_AND   = 5'd3;
	localparam oper_t OP_OR    = 5'd4;
	localparam oper_t OP_XOR   = 5'd5;
	localparam oper_t OP_NOR   = 5'd6;
	localparam oper_t OP_SLT   = 5'd7;
	localparam oper_t OP_SLTU  = 5'd8;
	localparam oper_t OP_SLL   = 5'd9;
	localparam oper_t OP_SRL   = 5'd10;
	localparam oper_t OP_SRA   = 5'd11;
	localparam oper_t OP_MULT  = 5'd12;
	localparam oper_t OP_MULTU = 5'd13;
	localparam oper_t OP_MFHI  = 5'd14;
	localparam oper_t OP_MFLO  = 5'd15;
	localparam oper_t OP_MTHI  = 5'd16;
	localparam oper_t OP_MTLO  = 5'd17;
	localparam oper_t OP_LUI   = 5'd18;

endpackage

`default_nettype wire

// File: source/mips_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module mips_regfile #(
	parameter int ADDR_W = $clog2(`MIPS_REG_COUNT)
) (
	input  wire logic              clk,
	input  wire logic              reset_i,
	input  wire logic              we_i,
	input  wire logic [ADDR_W-1:0] waddr_i,
	input  wire logic [31:0]       wdata_i,
	input  wire logic [ADDR_W-1:0] raddr1_i,
	input  wire logic [ADDR_W-1:0] raddr2_i,
	output      logic [31:0]       rdata1_o,
	output      logic [31:0]       rdata2_o
);

	logic [31:0] regs_q [`MIPS_REG_COUNT];

	// r0 is cleared by reset and never written
	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
				regs_q[i] <= '0;
			end
		end else if (we_i && (waddr_i != '0)) begin
			regs_q[waddr_i] <= wdata_i;
		end
	end

	assign rdata1_o = regs_q[raddr1_i];
	assign rdata2_o = regs_q[raddr2_i];

	// A commit from the result stage must name a real register
	a_waddr_known: assert property (
		@(posedge clk) disable iff (reset_i)
		we_i |-> !$isunknown(waddr_i)
	);

endmodule

`default_nettype wire

// File: source/mips_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module mips_fetch (
	input  wire logic                 clk,
	input  wire logic                 reset_i,
	output      mips_pkg::inst_addr_t ibus_addr_o,
	input  wire mips_pkg::inst_t      ibus_data_i,
	output      mips_pkg::inst_addr_t id_pc_o,
	output      mips_pkg::inst_t      id_inst_o
);

	mips_pkg::inst_addr_t pc_q;

	// Straight-line fetch, no branches
	always_ff @(posedge clk) begin
		if (reset_i) begin
			pc_q <= `MIPS_RESET_PC;
		end else begin
			pc_q <= pc_q + 32'd4;
		end
	end

	assign ibus_addr_o = pc_q;

	// Bus answers in the same cycle, so latch it straight into decode
	always_ff @(posedge clk) begin
		if (reset_i) begin
			id_inst_o <= '0;
		end else begin
			id_inst_o <= ibus_data_i;
		end
	end

	always_ff @(posedge clk) begin
		id_pc_o <= pc_q;
	end

endmodule

`default_nettype wire

// File: source/mips_decode.sv
`timescale 1ns/1ps
`default_nettype none

module mips_decode (
	input  wire logic                 clk,
	input  wire logic                 reset_i,
	input  wire mips_pkg::inst_addr_t pc_i,
	input  wire mips_pkg::inst_t      inst_i,
	output      mips_pkg::reg_addr_t  raddr1_o,
	output      mips_pkg::reg_addr_t  raddr2_o,
	input  wire mips_pkg::word_t      rdata1_i,
	input  wire mips_pkg::word_t      rdata2_i,
	input  wire logic                 fwd_ex_we_i,
	input  wire mips_pkg::reg_addr_t  fwd_ex_waddr_i,
	input  wire mips_pkg::word_t      fwd_ex_wdata_i,
	input  wire logic                 fwd_rs_we_i,
	input  wire mips_pkg::reg_addr_t  fwd_rs_waddr_i,
	input  wire mips_pkg::word_t      fwd_rs_wdata_i,
	output      mips_pkg::oper_t      op_o,
	output      mips_pkg::word_t      src1_o,
	output      mips_pkg::word_t      src2_o,
	output      logic                 we_o,
	output      mips_pkg::reg_addr_t  waddr_o
);

	logic [5:0]          opcode;
	logic [5:0]          funct;
	mips_pkg::reg_addr_t rs;
	mips_pkg::reg_addr_t rt;
	mips_pkg::reg_addr_t rd;
	logic [4:0]          sa;
	mips_pkg::word_t     imm_sext;
	mips_pkg::word_t     imm_zext;
	mips_pkg::word_t     reg1;
	mips_pkg::word_t     reg2;
	mips_pkg::oper_t     op_d;
	mips_pkg::word_t     src1_d;
	mips_pkg::word_t     src2_d;
	logic                we_d;
	mips_pkg::reg_addr_t waddr_d;

	assign opcode   = inst_i[31:26];
	assign rs       = inst_i[25:21];
	assign rt       = inst_i[20:16];
	assign rd       = inst_i[15:11];
	assign sa       = inst_i[10:6];
	assign funct    = inst_i[5:0];
	assign imm_sext = {{16{inst_i[15]}}, inst_i[15:0]};
	assign imm_zext = {16'h0000, inst_i[15:0]};

	assign raddr1_o = rs;
	assign raddr2_o = rt;

	// Newest value wins, execute before result before register file
	function automatic mips_pkg::word_t fwd_sel(
		input mips_pkg::reg_addr_t addr,
		input mips_pkg::word_t     rf_data
	);
		if (addr == '0)
			return '0;
		if (fwd_ex_we_i && (fwd_ex_waddr_i == addr))
			return fwd_ex_wdata_i;
		if (fwd_rs_we_i && (fwd_rs_waddr_i == addr))
			return fwd_rs_wdata_i;
		return rf_data;
	endfunction

	assign reg1 = fwd_sel(rs, rdata1_i);
	assign reg2 = fwd_sel(rt, rdata2_i);

	always_comb begin
		op_d    = mips_pkg::OP_NOP;
		we_d    = 1'b0;
		waddr_d = rd;
		src1_d  = reg1;
		src2_d  = reg2;
		case (opcode)
			6'h00: begin
				we_d = 1'b1;
				case (funct)
					6'h21: op_d = mips_pkg::OP_ADDU;
					6'h23: op_d = mips_pkg::OP_SUBU;
					6'h24: op_d = mips_pkg::OP_AND;
					6'h25: op_d = mips_pkg::OP_OR;
					6'h26: op_d = mips_pkg::OP_XOR;
					6'h27: op_d = mips_pkg::OP_NOR;
					6'h2a: op_d = mips_pkg::OP_SLT;
					6'h2b: op_d = mips_pkg::OP_SLTU;
					6'h10: op_d = mips_pkg::OP_MFHI;
					6'h12: op_d = mips_pkg::OP_MFLO;
					6'h00, 6'h02, 6'h03: begin
						// Shifts take rt as the value and sa as the amount
						op_d   = (funct == 6'h00) ? mips_pkg::OP_SLL :
						         (funct == 6'h02) ? mips_pkg::OP_SRL : mips_pkg::OP_SRA;
						src1_d = reg2;
						src2_d = {27'd0, sa};
					end
					6'h18, 6'h19: begin
						op_d = (funct == 6'h18) ? mips_pkg::OP_MULT : mips_pkg::OP_MULTU;
						we_d = 1'b0;
					end
					6'h11, 6'h13: begin
						op_d = (funct == 6'h11) ? mips_pkg::OP_MTHI : mips_pkg::OP_MTLO;
						we_d = 1'b0;
					end
					default: we_d = 1'b0;
				endcase
			end
			6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
				we_d    = 1'b1;
				waddr_d = rt;
				// ANDI/ORI/XORI/LUI zero-extend
				src2_d  = opcode[2] ? imm_zext : imm_sext;
				case (opcode)
					6'h09:   op_d = mips_pkg::OP_ADDU;
					6'h0a:   op_d = mips_pkg::OP_SLT;
					6'h0b:   op_d = mips_pkg::OP_SLTU;
					6'h0c:   op_d = mips_pkg::OP_AND;
					6'h0d:   op_d = mips_pkg::OP_OR;
					6'h0e:   op_d = mips_pkg::OP_XOR;
					default: op_d = mips_pkg::OP_LUI;
				endcase
			end
			default: we_d = 1'b0;
		endcase
		if (waddr_d == '0)
			we_d = 1'b0;
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			op_o    <= mips_pkg::OP_NOP;
			we_o    <= 1'b0;
			waddr_o <= '0;
		end else begin
			op_o    <= op_d;
			we_o    <= we_d;
			waddr_o <= waddr_d;
		end
	end

	always_ff @(posedge clk) begin
		src1_o <= src1_d;
		src2_o <= src2_d;
	end

	a_no_r0_write: assert property (
		@(posedge clk) disable iff (reset_i)
		we_o |-> (waddr_o != '0)
	);

endmodule

`default_nettype wire

// File: source/mips_execute.sv
`timescale 1ns/1ps
`default_nettype none

module mips_execute (
	input  wire logic                clk,
	input  wire logic                reset_i,
	input  wire mips_pkg::oper_t     op_i,
	input  wire mips_pkg::word_t     src1_i,
	input  wire mips_pkg::word_t     src2_i,
	input  wire logic                we_i,
	input  wire mips_pkg::reg_addr_t waddr_i,
	input  wire mips_pkg::dword_t    hilo_i,
	output      logic                fwd_we_o,
	output      mips_pkg::reg_addr_t fwd_waddr_o,
	output      mips_pkg::word_t     fwd_wdata_o,
	output      logic                rs_we_o,
	output      mips_pkg::reg_addr_t rs_waddr_o,
	output      mips_pkg::word_t     rs_wdata_o,
	output      logic                rs_hilo_we_o,
	output      mips_pkg::dword_t    rs_hilo_wdata_o
);

	mips_pkg::dword_t hilo_cur;
	mips_pkg::dword_t prod_s;
	mips_pkg::dword_t prod_u;
	mips_pkg::word_t  result_d;
	logic             hilo_we_d;
	mips_pkg::dword_t hilo_wdata_d;

	// HI/LO write still sitting in the result register
	assign hilo_cur = rs_hilo_we_o ? rs_hilo_wdata_o : hilo_i;

	assign prod_s = $signed({{32{src1_i[31]}}, src1_i}) * $signed({{32{src2_i[31]}}, src2_i});
	assign prod_u = {32'd0, src1_i} * {32'd0, src2_i};

	always_comb begin
		case (op_i)
			mips_pkg::OP_ADDU: result_d = src1_i + src2_i;
			mips_pkg::OP_SUBU: result_d = src1_i - src2_i;
			mips_pkg::OP_AND:  result_d = src1_i & src2_i;
			mips_pkg::OP_OR:   result_d = src1_i | src2_i;
			mips_pkg::OP_XOR:  result_d = src1_i ^ src2_i;
			mips_pkg::OP_NOR:  result_d = ~(src1_i | src2_i);
			mips_pkg::OP_SLT:  result_d = {31'd0, ($signed(src1_i) < $signed(src2_i))};
			mips_pkg::OP_SLTU: result_d = {31'd0, (src1_i < src2_i)};
			mips_pkg::OP_SLL:  result_d = src1_i << src2_i[4:0];
			mips_pkg::OP_SRL:  result_d = src1_i >> src2_i[4:0];
			mips_pkg::OP_SRA:  result_d = $signed(src1_i) >>> src2_i[4:0];
			mips_pkg::OP_MFHI: result_d = hilo_cur[63:32];
			mips_pkg::OP_MFLO: result_d = hilo_cur[31:0];
			mips_pkg::OP_LUI:  result_d = {src2_i[15:0], 16'h0000};
			default:           result_d = '0;
		endcase
	end

	always_comb begin
		hilo_we_d    = 1'b1;
		hilo_wdata_d = hilo_cur;
		case (op_i)
			mips_pkg::OP_MULT:  hilo_wdata_d = prod_s;
			mips_pkg::OP_MULTU: hilo_wdata_d = prod_u;
			mips_pkg::OP_MTHI:  hilo_wdata_d = {src1_i, hilo_cur[31:0]};
			mips_pkg::OP_MTLO:  hilo_wdata_d = {hilo_cur[63:32], src1_i};
			default:            hilo_we_d = 1'b0;
		endcase
	end

	assign fwd_we_o    = we_i;
	assign fwd_waddr_o = waddr_i;
	assign fwd_wdata_o = result_d;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			rs_we_o      <= 1'b0;
			rs_waddr_o   <= '0;
			rs_hilo_we_o <= 1'b0;
		end else begin
			rs_we_o      <= we_i;
			rs_waddr_o   <= waddr_i;
			rs_hilo_we_o <= hilo_we_d;
		end
	end

	always_ff @(posedge clk) begin
		rs_wdata_o      <= result_d;
		rs_hilo_wdata_o <= hilo_wdata_d;
	end

	a_op_known: assert property (
		@(posedge clk) disable iff (reset_i)
		!$isunknown(op_i)
	);

endmodule

`default_nettype wire

// File: source/mips_result.sv
`timescale 1ns/1ps
`default_nettype none

module mips_result (
	input  wire logic                clk,
	input  wire logic                reset_i,
	input  wire logic                we_i,
	input  wire mips_pkg::reg_addr_t waddr_i,
	input  wire mips_pkg::word_t     wdata_i,
	input  wire logic                hilo_we_i,
	input  wire mips_pkg::dword_t    hilo_wdata_i,
	output      mips_pkg::dword_t    hilo_o,
	output      logic                wb_we_o,
	output      mips_pkg::reg_addr_t wb_waddr_o,
	output      mips_pkg::word_t     wb_wdata_o
);

	mips_pkg::dword_t hilo_q;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			hilo_q <= '0;
		end else if (hilo_we_i) begin
			hilo_q <= hilo_wdata_i;
		end
	end

	assign hilo_o = hilo_q;

	// Commit port, also the trace seen outside the core
	assign wb_we_o    = we_i & (waddr_i != '0);
	assign wb_waddr_o = waddr_i;
	assign wb_wdata_o = wdata_i;

	a_wb_we_known: assert property (
		@(posedge clk) disable iff (reset_i)
		!$isunknown(wb_we_o)
	);

endmodule

`default_nettype wire

// File: source/mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core (
	input  wire logic                 clk,
	input  wire logic                 reset_i,
	output      mips_pkg::inst_addr_t ibus_addr_o,
	input  wire mips_pkg::inst_t      ibus_data_i,
	output      logic                 wb_we_o,
	output      mips_pkg::reg_addr_t  wb_waddr_o,
	output      mips_pkg::word_t      wb_wdata_o
);

	mips_pkg::inst_addr_t id_pc;
	mips_pkg::inst_t      id_inst;
	mips_pkg::reg_addr_t  raddr1;
	mips_pkg::reg_addr_t  raddr2;
	mips_pkg::word_t      rdata1;
	mips_pkg::word_t      rdata2;
	mips_pkg::oper_t      ex_op;
	mips_pkg::word_t      ex_src1;
	mips_pkg::word_t      ex_src2;
	logic                 ex_we;
	mips_pkg::reg_addr_t  ex_waddr;
	logic                 ex_fwd_we;
	mips_pkg::reg_addr_t  ex_fwd_waddr;
	mips_pkg::word_t      ex_wdata;
	logic                 rs_we;
	mips_pkg::reg_addr_t  rs_waddr;
	mips_pkg::word_t      rs_wdata;
	logic                 rs_hilo_we;
	mips_pkg::dword_t     rs_hilo_wdata;
	mips_pkg::dword_t     hilo_q;

	mips_fetch fetch_inst (
		.clk,
		.reset_i,
		.ibus_addr_o,
		.ibus_data_i,
		.id_pc_o   (id_pc),
		.id_inst_o (id_inst)
	);

	// Written back from the result stage commit port
	mips_regfile regfile_inst (
		.clk,
		.reset_i,
		.we_i     (wb_we_o),
		.waddr_i  (wb_waddr_o),
		.wdata_i  (wb_wdata_o),
		.raddr1_i (raddr1),
		.raddr2_i (raddr2),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2)
	);

	mips_decode decode_inst (
		.clk,
		.reset_i,
		.pc_i           (id_pc),
		.inst_i         (id_inst),
		.raddr1_o       (raddr1),
		.raddr2_o       (raddr2),
		.rdata1_i       (rdata1),
		.rdata2_i       (rdata2),
		.fwd_ex_we_i    (ex_fwd_we),
		.fwd_ex_waddr_i (ex_fwd_waddr),
		.fwd_ex_wdata_i (ex_wdata),
		.fwd_rs_we_i    (rs_we),
		.fwd_rs_waddr_i (rs_waddr),
		.fwd_rs_wdata_i (rs_wdata),
		.op_o           (ex_op),
		.src1_o         (ex_src1),
		.src2_o         (ex_src2),
		.we_o           (ex_we),
		.waddr_o        (ex_waddr)
	);

	mips_execute execute_inst (
		.clk,
		.reset_i,
		.op_i            (ex_op),
		.src1_i          (ex_src1),
		.src2_i          (ex_src2),
		.we_i            (ex_we),
		.waddr_i         (ex_waddr),
		.hilo_i          (hilo_q),
		.fwd_we_o        (ex_fwd_we),
		.fwd_waddr_o     (ex_fwd_waddr),
		.fwd_wdata_o     (ex_wdata),
		.rs_we_o         (rs_we),
		.rs_waddr_o      (rs_waddr),
		.rs_wdata_o      (rs_wdata),
		.rs_hilo_we_o    (rs_hilo_we),
		.rs_hilo_wdata_o (rs_hilo_wdata)
	);

	mips_result result_inst (
		.clk,
		.reset_i,
		.we_i         (rs_we),
		.waddr_i      (rs_waddr),
		.wdata_i      (rs_wdata),
		.hilo_we_i    (rs_hilo_we),
		.hilo_wdata_i (rs_hilo_wdata),
		.hilo_o       (hilo_q),
		.wb_we_o,
		.wb_waddr_o,
		.wb_wdata_o
	);

endmodule

`default_nettype wire

// File: bench/mips_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_config.svh"

module mips_core_tb;

	localparam int PROG_LEN = 200;
	localparam int DIRECTED = 16;

	logic        clk;
	logic        reset_i;
	logic [31:0] ibus_addr_o;
	logic [31:0] ibus_data_i;
	logic        wb_we_o;
	logic [4:0]  wb_waddr_o;
	logic [31:0] wb_wdata_o;

	integer      seed;
	int          error_count;
	int          write_count;
	logic [31:0] prog [PROG_LEN];
	logic [31:0] model_regs [32];
	logic [31:0] model_hi;
	logic [31:0] model_lo;
	logic [4:0]  exp_waddr [$];
	logic [31:0] exp_wdata [$];
	int          exp_slot [$];

	mips_core mips_core_inst (
		.clk         (clk),
		.reset_i     (reset_i),
		.ibus_addr_o (ibus_addr_o),
		.ibus_data_i (ibus_data_i),
		.wb_we_o     (wb_we_o),
		.wb_waddr_o  (wb_waddr_o),
		.wb_wdata_o  (wb_wdata_o)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] r_inst(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] sa, input logic [5:0] fn);
		return {6'h00, rs, rt, rd, sa, fn};
	endfunction

	function automatic logic [31:0] i_inst(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Few registers, so dependencies come close together
	function automatic logic [4:0] pick_reg();
		return 5'($unsigned($random(seed)) % 6);
	endfunction

	function automatic logic [31:0] random_inst();
		int          kind;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [31:0] bits;
		logic [5:0]  fn;
		kind = $unsigned($random(seed)) % 26;
		rs = pick_reg();
		rt = pick_reg();
		rd = pick_reg();
		bits = $random(seed);
		if (kind >= 17 && kind <= 23)
			return i_inst(6'h09 + 6'(kind - 17), rs, rt, bits[15:0]);
		if (kind == 24)
			return r_inst(rs, rt, rd, bits[10:6], 6'h3e);
		// Load/store opcodes, not implemented
		if (kind == 25)
			return {3'b100, bits[2:0], bits[25:0]};
		case (kind)
			0:       fn = 6'h21;
			1:       fn = 6'h23;
			2:       fn = 6'h24;
			3:       fn = 6'h25;
			4:       fn = 6'h26;
			5:       fn = 6'h27;
			6:       fn = 6'h2a;
			7:       fn = 6'h2b;
			8:       fn = 6'h00;
			9:       fn = 6'h02;
			10:      fn = 6'h03;
			11:      fn = 6'h18;
			12:      fn = 6'h19;
			13:      fn = 6'h10;
			14:      fn = 6'h12;
			15:      fn = 6'h11;
			default: fn = 6'h13;
		endcase
		return r_inst(rs, rt, rd, bits[10:6], fn);
	endfunction

	task automatic build_program();
		// HI/LO sequences back to back, then r0 traffic
		prog[0]  = i_inst(6'h0d, 5'd0, 5'd1, 16'h8001);
		prog[1]  = i_inst(6'h0f, 5'd0, 5'd2, 16'hfffe);
		prog[2]  = i_inst(6'h0d, 5'd2, 5'd2, 16'h1234);
		prog[3]  = r_inst(5'd1, 5'd2, 5'd0, 5'd0, 6'h18);
		prog[4]  = r_inst(5'd0, 5'd0, 5'd3, 5'd0, 6'h10);
		prog[5]  = r_inst(5'd0, 5'd0, 5'd4, 5'd0, 6'h12);
		prog[6]  = r_inst(5'd2, 5'd2, 5'd0, 5'd0, 6'h19);
		prog[7]  = r_inst(5'd0, 5'd0, 5'd5, 5'd0, 6'h12);
		prog[8]  = r_inst(5'd0, 5'd0, 5'd1, 5'd0, 6'h10);
		prog[9]  = r_inst(5'd3, 5'd0, 5'd0, 5'd0, 6'h11);
		prog[10] = r_inst(5'd0, 5'd0, 5'd2, 5'd0, 6'h10);
		prog[11] = r_inst(5'd2, 5'd0, 5'd0, 5'd0, 6'h13);
		prog[12] = r_inst(5'd0, 5'd0, 5'd3, 5'd0, 6'h12);
		prog[13] = r_inst(5'd1, 5'd2, 5'd0, 5'd0, 6'h21);
		prog[14] = r_inst(5'd0, 5'd5, 5'd4, 5'd0, 6'h21);
		prog[15] = r_inst(5'd4, 5'd1, 5'd5, 5'd0, 6'h23);
		for (int i = DIRECTED; i < PROG_LEN; i++)
			prog[i] = random_inst();
	endtask

	// Sequential ISA model, one instruction at a time
	task automatic run_model();
		logic [31:0] inst;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] sext;
		logic [63:0] prod;
		logic [5:0]  op;
		logic [5:0]  fn;
		logic [4:0]  dst;
		logic        wr;
		for (int r = 0; r < 32; r++)
			model_regs[r] = '0;
		model_hi = '0;
		model_lo = '0;
		for (int i = 0; i < PROG_LEN; i++) begin
			inst = prog[i];
			op   = inst[31:26];
			fn   = inst[5:0];
			a    = model_regs[inst[25:21]];
			b    = model_regs[inst[20:16]];
			sext = {{16{inst[15]}}, inst[15:0]};
			dst  = inst[15:11];
			res  = '0;
			wr   = 1'b0;
			case (op)
				6'h00: begin
					wr = 1'b1;
					case (fn)
						6'h21: res = a + b;
						6'h23: res = a - b;
						6'h24: res = a & b;
						6'h25: res = a | b;
						6'h26: res = a ^ b;
						6'h27: res = ~(a | b);
						6'h2a: res = {31'd0, $signed(a) < $signed(b)};
						6'h2b: res = {31'd0, a < b};
						6'h00: res = b << inst[10:6];
						6'h02: res = b >> inst[10:6];
						6'h03: res = $signed(b) >>> inst[10:6];
						6'h10: res = model_hi;
						6'h12: res = model_lo;
						6'h18, 6'h19: begin
							if (fn == 6'h18)
								prod = longint'($signed(a)) * longint'($signed(b));
							else
								prod = 64'(a) * 64'(b);
							{model_hi, model_lo} = prod;
							wr = 1'b0;
						end
						6'h11: begin
							model_hi = a;
							wr = 1'b0;
						end
						6'h13: begin
							model_lo = a;
							wr = 1'b0;
						end
						default: wr = 1'b0;
					endcase
				end
				6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
					wr  = 1'b1;
					dst = inst[20:16];
					case (op)
						6'h09:   res = a + sext;
						6'h0a:   res = {31'd0, $signed(a) < $signed(sext)};
						6'h0b:   res = {31'd0, a < sext};
						6'h0c:   res = a & {16'h0000, inst[15:0]};
						6'h0d:   res = a | {16'h0000, inst[15:0]};
						6'h0e:   res = a ^ {16'h0000, inst[15:0]};
						default: res = {inst[15:0], 16'h0000};
					endcase
				end
				default: wr = 1'b0;
			endcase
			if (wr && dst != 5'd0) begin
				model_regs[dst] = res;
				exp_waddr.push_back(dst);
				exp_wdata.push_back(res);
				exp_slot.push_back(i);
			end
		end
	endtask

	function automatic logic [31:0] fetch_word(input logic [31:0] addr);
		logic [31:0] offset;
		offset = addr - `MIPS_RESET_PC;
		if (offset[1:0] != 2'b00 || (offset >> 2) >= PROG_LEN)
			return 32'h0;
		return prog[offset >> 2];
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAILED %s: expected 0x%08h, got 0x%08h", name, expected, actual);
			error_count++;
		end
	endtask

	// Called at a falling edge, k counts cycles since reset release
	task automatic observe_cycle(input int k);
		check_value("ibus_addr_o", ibus_addr_o, `MIPS_RESET_PC + 32'(4 * k));
		if (k < 3)
			check_value("wb_we_o", {31'd0, wb_we_o}, 32'd0);
		if (wb_we_o === 1'b1) begin
			if (exp_waddr.size() == 0) begin
				$display("Unexpected write to r%0d in cycle %0d after all expected writes",
					wb_waddr_o, k);
				error_count++;
			end else begin
				check_value("wb_waddr_o", {27'd0, wb_waddr_o}, {27'd0, exp_waddr[0]});
				check_value("wb_wdata_o", wb_wdata_o, exp_wdata[0]);
				check_value("write cycle", k, exp_slot[0] + 3);
				void'(exp_waddr.pop_front());
				void'(exp_wdata.pop_front());
				void'(exp_slot.pop_front());
				write_count++;
			end
		end
		ibus_data_i = fetch_word(ibus_addr_o);
	endtask

	initial begin
		int k;
		int waited;
		seed        = 32'h3f52ca55;
		error_count = 0;
		write_count = 0;
		reset_i     = 1'b1;
		ibus_data_i = '0;
		build_program();
		run_model();
		repeat (9) begin
			@(negedge clk);
			check_value("wb_we_o", {31'd0, wb_we_o}, 32'd0);
		end
		k = 0;
		while (k < PROG_LEN + 3) begin
			@(negedge clk);
			if (k == 0)
				reset_i = 1'b0;
			observe_cycle(k);
			k++;
		end
		waited = 0;
		while (exp_waddr.size() != 0 && waited < 16) begin
			@(negedge clk);
			observe_cycle(k);
			k++;
			waited++;
		end
		if (exp_waddr.size() != 0) begin
			$display("Timed out with %0d expected writes never seen on the trace",
				exp_waddr.size());
			error_count++;
		end
		// Only zero words left in flight, nothing may commit
		repeat (8) begin
			@(negedge clk);
			observe_cycle(k);
			k++;
		end
		$display("Checked %0d writes, %0d errors", write_count, error_count);
		if (error_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+source
source/mips_pkg.sv
source/mips_regfile.sv
source/mips_fetch.sv
source/mips_decode.sv
source/mips_execute.sv
source/mips_result.sv
source/mips_core.sv
bench/mips_core_tb.sv

// File: Bender.yml
package:
  name: mips_core

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/mips_pkg.sv
      - source/mips_regfile.sv
      - source/mips_fetch.sv
      - source/mips_decode.sv
      - source/mips_execute.sv
      - source/mips_result.sv
      - source/mips_core.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/mips_core_tb.sv
